//--- logic/cpuPkg.sv
// widths, memory depth and T-state limits of the accumulator CPU
// opcode, bus-source and ALU-operation enums

package cpuPkg;

    localparam int wordWidth = 16;
    localparam int addrWidth = 8;
    localparam int memDepth = 256;

    // last T-state any instruction uses; LDX, LDY and STX reach it.
    localparam int unsigned maxTState = 3;
    localparam int tStateWidth = 3;

    typedef enum logic [3:0] {
        NOP,
        LDX,
        LDY,
        LDI,  // immediate goes to X.
        STX,
        ADD,
        SUB,
        AND,
        JMP,
        JC,
        JZ,
        JGT,
        JLT,
        IN,
        OUT,
        HLT
    } opcodeE;

    // exactly one source drives the bus each cycle.
    typedef enum logic [2:0] {
        srcNone,  // bus reads as zero.
        srcPc,
        srcOperand,
        srcMemory,
        srcAlu,
        srcXReg,
        srcExtIn
    } busSrcE;

    typedef enum logic [1:0] {
        aluAdd,
        aluSub,
        aluAnd
    } aluOpE;

endpackage

//--- logic/aluFlags.sv
// ALU for ADD, SUB and AND
// carry, zero and signed less-than flag register

module aluFlags (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic [cpuPkg::wordWidth-1:0]    xVal,
    input  logic [cpuPkg::wordWidth-1:0]    yVal,
    input  cpuPkg::aluOpE                   aluOp,
    input  logic                            flagLoad,
    output logic [cpuPkg::wordWidth-1:0]    aluResult,
    output logic                            carry,
    output logic                            zero,
    output logic                            less
);

    logic [cpuPkg::wordWidth:0] wideResult;  // top bit is carry out or borrow.
    logic                       carryNext;

    always_comb begin
        case (aluOp)
            cpuPkg::aluSub: begin
                wideResult = {1'b0, xVal} - {1'b0, yVal};
                carryNext  = !wideResult[cpuPkg::wordWidth];  // set when no borrow.
            end
            cpuPkg::aluAnd: begin
                wideResult = {1'b0, xVal & yVal};
                carryNext  = 1'b0;
            end
            default: begin
                wideResult = {1'b0, xVal} + {1'b0, yVal};
                carryNext  = wideResult[cpuPkg::wordWidth];
            end
        endcase
    end

    assign aluResult = wideResult[cpuPkg::wordWidth-1:0];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            carry <= 1'b0;
            zero  <= 1'b0;
            less  <= 1'b0;
        end else if (flagLoad) begin
            carry <= carryNext;
            zero  <= (aluResult == '0);
            less  <= ($signed(xVal) < $signed(yVal));  // signed compare for every op.
        end
    end

endmodule

//--- logic/busDatapath.sv
// bus multiplexer over the seven sources
// X, Y and address registers loaded from the bus

module busDatapath (
    input  logic                            clk,
    input  logic                            rstN,
    input  cpuPkg::busSrcE                  busSrc,
    input  logic [cpuPkg::addrWidth-1:0]    operand,
    input  logic [cpuPkg::addrWidth-1:0]    pcVal,
    input  logic [cpuPkg::wordWidth-1:0]    memData,
    input  logic [cpuPkg::wordWidth-1:0]    aluResult,
    input  logic [cpuPkg::wordWidth-1:0]    inData,
    input  logic                            xLoad,
    input  logic                            yLoad,
    input  logic                            arLoad,
    output logic [cpuPkg::wordWidth-1:0]    busVal,
    output logic [cpuPkg::wordWidth-1:0]    xVal,
    output logic [cpuPkg::wordWidth-1:0]    yVal,
    output logic [cpuPkg::addrWidth-1:0]    arVal
);

    localparam int padWidth = cpuPkg::wordWidth - cpuPkg::addrWidth;

    always_comb begin
        case (busSrc)
            cpuPkg::srcPc:      busVal = {{padWidth{1'b0}}, pcVal};
            cpuPkg::srcOperand: busVal = {{padWidth{1'b0}}, operand};  // zero-extended byte.
            cpuPkg::srcMemory:  busVal = memData;
            cpuPkg::srcAlu:     busVal = aluResult;
            cpuPkg::srcXReg:    busVal = xVal;
            cpuPkg::srcExtIn:   busVal = inData;
            default:            busVal = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            xVal  <= '0;
            yVal  <= '0;
            arVal <= '0;
        end else begin
            if (xLoad) begin
                xVal <= busVal;
            end
            if (yLoad) begin
                yVal <= busVal;
            end
            if (arLoad) begin
                arVal <= busVal[cpuPkg::addrWidth-1:0];
            end
        end
    end

    // an AR load always has a real source behind it.
    arLoadDriven: assert property (@(posedge clk) disable iff (!rstN)
        !(arLoad && busSrc == cpuPkg::srcNone));

endmodule

//--- logic/programCounter.sv
// program counter with increment and jump load

module programCounter (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic [cpuPkg::wordWidth-1:0]    busVal,
    input  logic                            pcLoad,
    input  logic                            pcInc,
    output logic [cpuPkg::addrWidth-1:0]    pcVal
);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pcVal <= '0;
        end else if (pcLoad) begin
            pcVal <= busVal[cpuPkg::addrWidth-1:0];  // jump target is the operand byte.
        end else if (pcInc) begin
            pcVal <= pcVal + 1'b1;  // wraps at 256.
        end
    end

endmodule

//--- logic/programMemory.sv
// shared program and data memory
// asynchronous read, bus write and loader write

module programMemory (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic [cpuPkg::addrWidth-1:0]    arVal,
    input  logic [cpuPkg::wordWidth-1:0]    busVal,
    input  logic                            memWrite,
    input  logic                            progWe,
    input  logic [cpuPkg::addrWidth-1:0]    progAddr,
    input  logic [cpuPkg::wordWidth-1:0]    progData,
    output logic [cpuPkg::wordWidth-1:0]    memData
);

    logic [cpuPkg::wordWidth-1:0] mem [cpuPkg::memDepth];

    assign memData = mem[arVal];

    always_ff @(posedge clk) begin
        if (progWe) begin
            mem[progAddr] <= progData;  // loader owns the array during reset.
        end else if (memWrite) begin
            mem[arVal] <= busVal;
        end
    end

    // loading while the core runs would race with fetches.
    loaderInReset: assert property (@(posedge clk) progWe |-> !rstN);

endmodule

//--- logic/microSequencer.sv
// instruction register, T-state counter and halt latch
// microcode decode of opcode and T-state, jump conditions

module microSequencer (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic [cpuPkg::wordWidth-1:0]    busVal,
    input  logic                            carry,
    input  logic                            zero,
    input  logic                            less,
    output cpuPkg::busSrcE                  busSrc,
    output logic [cpuPkg::addrWidth-1:0]    operand,
    output logic                            xLoad,
    output logic                            yLoad,
    output logic                            arLoad,
    output logic                            memWrite,
    output logic                            pcLoad,
    output logic                            pcInc,
    output logic                            flagLoad,
    output cpuPkg::aluOpE                   aluOp,
    output logic                            outStrobe,
    output logic                            inStrobe,
    output logic                            halted
);

    logic [cpuPkg::wordWidth-1:0]   ir;
    logic [cpuPkg::tStateWidth-1:0] tState;
    cpuPkg::opcodeE                 opcode;
    logic                           irLoad;
    logic                           tReset;
    logic                           haltSet;
    logic                           jumpTaken;

    assign opcode  = cpuPkg::opcodeE'(ir[15:12]);
    assign operand = ir[cpuPkg::addrWidth-1:0];  // bits 11..8 are unused.

    always_comb begin
        case (opcode)
            cpuPkg::JMP: jumpTaken = 1'b1;
            cpuPkg::JC:  jumpTaken = carry;
            cpuPkg::JZ:  jumpTaken = zero;
            cpuPkg::JGT: jumpTaken = !zero && !less;
            cpuPkg::JLT: jumpTaken = less;
            default:     jumpTaken = 1'b0;
        endcase
    end

    always_comb begin
        case (opcode)
            cpuPkg::SUB: aluOp = cpuPkg::aluSub;
            cpuPkg::AND: aluOp = cpuPkg::aluAnd;
            default:     aluOp = cpuPkg::aluAdd;
        endcase
    end

    always_comb begin
        busSrc    = cpuPkg::srcNone;
        xLoad     = 1'b0;
        yLoad     = 1'b0;
        arLoad    = 1'b0;
        memWrite  = 1'b0;
        pcLoad    = 1'b0;
        pcInc     = 1'b0;
        flagLoad  = 1'b0;
        outStrobe = 1'b0;
        inStrobe  = 1'b0;
        irLoad    = 1'b0;
        tReset    = 1'b0;
        haltSet   = 1'b0;
        case (tState)
            3'd0: begin  // fetch address.
                busSrc = cpuPkg::srcPc;
                arLoad = 1'b1;
            end
            3'd1: begin  // fetch word into IR.
                busSrc = cpuPkg::srcMemory;
                irLoad = 1'b1;
                pcInc  = 1'b1;
            end
            3'd2: begin
                tReset = 1'b1;
                case (opcode)
                    cpuPkg::LDX, cpuPkg::LDY, cpuPkg::STX: begin
                        busSrc = cpuPkg::srcOperand;
                        arLoad = 1'b1;
                        tReset = 1'b0;  // these need T3.
                    end
                    cpuPkg::LDI: begin
                        busSrc = cpuPkg::srcOperand;
                        xLoad  = 1'b1;
                    end
                    cpuPkg::ADD, cpuPkg::SUB, cpuPkg::AND: begin
                        busSrc   = cpuPkg::srcAlu;
                        xLoad    = 1'b1;
                        flagLoad = 1'b1;
                    end
                    cpuPkg::JMP, cpuPkg::JC, cpuPkg::JZ, cpuPkg::JGT, cpuPkg::JLT: begin
                        busSrc = cpuPkg::srcOperand;
                        pcLoad = jumpTaken;
                    end
                    cpuPkg::IN: begin
                        busSrc   = cpuPkg::srcExtIn;
                        xLoad    = 1'b1;
                        inStrobe = 1'b1;
                    end
                    cpuPkg::OUT: begin
                        busSrc    = cpuPkg::srcXReg;
                        outStrobe = 1'b1;
                    end
                    cpuPkg::HLT: begin
                        haltSet = 1'b1;
                        tReset  = 1'b0;  // parks in T2 until reset.
                    end
                    default: ;
                endcase
            end
            3'd3: begin
                tReset = 1'b1;
                busSrc = (opcode == cpuPkg::STX) ? cpuPkg::srcXReg : cpuPkg::srcMemory;
                xLoad    = (opcode == cpuPkg::LDX);
                yLoad    = (opcode == cpuPkg::LDY);
                memWrite = (opcode == cpuPkg::STX);
            end
            default: tReset = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ir      <= '0;
            tState  <= '0;
            halted  <= 1'b0;
        end else begin
            if (irLoad) begin
                ir <= busVal;
            end
            if (tReset) begin
                tState <= '0;
            end else if (!haltSet) begin
                tState <= tState + 1'b1;
            end
            if (haltSet) begin
                halted <= 1'b1;
            end
        end
    end

    tStateBound: assert property (@(posedge clk) disable iff (!rstN)
        tState <= cpuPkg::maxTState);
    pcSingleUpdate: assert property (@(posedge clk) disable iff (!rstN)
        !(pcLoad && pcInc));

endmodule

//--- logic/cpuTop.sv
// top level of the accumulator CPU
// sequencer, datapath, ALU, PC and memory wired to the pins

module cpuTop (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic [cpuPkg::wordWidth-1:0]    inData,
    input  logic                            progWe,
    input  logic [cpuPkg::addrWidth-1:0]    progAddr,
    input  logic [cpuPkg::wordWidth-1:0]    progData,
    output logic [cpuPkg::wordWidth-1:0]    outData,
    output logic                            outStrobe,
    output logic                            inStrobe,
    output logic [cpuPkg::addrWidth-1:0]    addr,
    output logic                            halted
);

    cpuPkg::busSrcE                 busSrc;
    cpuPkg::aluOpE                  aluOp;
    logic [cpuPkg::wordWidth-1:0]   busVal;
    logic [cpuPkg::wordWidth-1:0]   yVal;
    logic [cpuPkg::wordWidth-1:0]   memData;
    logic [cpuPkg::wordWidth-1:0]   aluResult;
    logic [cpuPkg::addrWidth-1:0]   operand;
    logic [cpuPkg::addrWidth-1:0]   pcVal;
    logic                           xLoad;
    logic                           yLoad;
    logic                           arLoad;
    logic                           memWrite;
    logic                           pcLoad;
    logic                           pcInc;
    logic                           flagLoad;
    logic                           carry;
    logic                           zero;
    logic                           less;

    microSequencer seq (
        .clk(clk), .rstN(rstN), .busVal(busVal),
        .carry(carry), .zero(zero), .less(less),
        .busSrc(busSrc), .operand(operand),
        .xLoad(xLoad), .yLoad(yLoad), .arLoad(arLoad), .memWrite(memWrite),
        .pcLoad(pcLoad), .pcInc(pcInc), .flagLoad(flagLoad), .aluOp(aluOp),
        .outStrobe(outStrobe), .inStrobe(inStrobe), .halted(halted)
    );

    // X is the output port and AR the address port.
    busDatapath datapath (
        .clk(clk), .rstN(rstN), .busSrc(busSrc), .operand(operand),
        .pcVal(pcVal), .memData(memData), .aluResult(aluResult), .inData(inData),
        .xLoad(xLoad), .yLoad(yLoad), .arLoad(arLoad),
        .busVal(busVal), .xVal(outData), .yVal(yVal), .arVal(addr)
    );

    aluFlags alu (
        .clk(clk), .rstN(rstN), .xVal(outData), .yVal(yVal),
        .aluOp(aluOp), .flagLoad(flagLoad), .aluResult(aluResult),
        .carry(carry), .zero(zero), .less(less)
    );

    programCounter pc (
        .clk(clk), .rstN(rstN), .busVal(busVal),
        .pcLoad(pcLoad), .pcInc(pcInc), .pcVal(pcVal)
    );

    programMemory memory (
        .clk(clk), .rstN(rstN), .arVal(addr), .busVal(busVal), .memWrite(memWrite),
        .progWe(progWe), .progAddr(progAddr), .progData(progData), .memData(memData)
    );

endmodule

//--- sim/cpuTb.sv
// testbench for the accumulator CPU with clock, reset, loader and program table
// LFSR operands, ALU and jump reference model, output checks and timeout

module cpuTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int numTests = 7;
    localparam int imageWords = 16;
    localparam int maxOuts = 4;
    localparam int resetCycles = 16;
    localparam int watchCycles = 8;
    localparam int loopBound = 5;
    localparam int cycleLimit = numTests * (4 * 16 * loopBound + resetCycles + 2 + watchCycles);
    localparam logic [7:0] dataA = 8'd12;  // data words sit above the program.
    localparam logic [7:0] dataB = 8'd13;
    localparam logic [7:0] dataC = 8'd14;

    logic        clk = 1'b0;
    logic        rstN;
    logic [15:0] inData;
    logic        progWe;
    logic [7:0]  progAddr;
    logic [15:0] progData;
    logic [15:0] outData;
    logic        outStrobe;
    logic        inStrobe;
    logic [7:0]  addr;
    logic        halted;

    string       testName [numTests];
    logic [15:0] image [numTests][imageWords];
    logic [15:0] inValue [numTests];
    logic [15:0] expOut [numTests][maxOuts];
    int          expCount [numTests];
    int          expIns [numTests];
    logic [7:0]  haltAddr [numTests];  // address of the HLT that parks the CPU.
    logic [31:0] lfsrState = 32'h0781_2913;
    int          cycleCount = 0;

    cpuTop dut (
        .clk(clk), .rstN(rstN), .inData(inData), .progWe(progWe),
        .progAddr(progAddr), .progData(progData), .outData(outData),
        .outStrobe(outStrobe), .inStrobe(inStrobe), .addr(addr), .halted(halted)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("the CPU did not finish all programs within %0d cycles", cycleLimit);
            $display("Something failed");
            $fatal(1, "timeout");
        end
    end

    // taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [15:0] randBits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrStep(lfsrState);
            v = {v[14:0], lfsrState[0]};
        end
        return v;
    endfunction

    function automatic logic [15:0] instr(input cpuPkg::opcodeE op, input logic [7:0] arg);
        return {op, 4'h0, arg};  // bits 11..8 stay zero.
    endfunction

    function automatic logic [15:0] aluModel(input cpuPkg::opcodeE op, input logic [15:0] x,
            input logic [15:0] y, output logic c, output logic z, output logic l);
        logic [15:0] r;
        if (op == cpuPkg::SUB) begin
            r = x - y;
            c = (x >= y);  // no borrow.
        end else if (op == cpuPkg::AND) begin
            r = x & y;
            c = 1'b0;
        end else begin
            r = x + y;
            c = (32'(x) + 32'(y)) > 32'hFFFF;
        end
        z = (r == 16'h0);
        l = ($signed(x) < $signed(y));
        return r;
    endfunction

    function automatic logic jumpModel(input cpuPkg::opcodeE op, input logic c,
            input logic z, input logic l);
        case (op)
            cpuPkg::JMP: return 1'b1;
            cpuPkg::JC:  return c;
            cpuPkg::JZ:  return z;
            cpuPkg::JLT: return l;
            cpuPkg::JGT: return !z && !l;
            default:     return 1'b0;
        endcase
    endfunction

    task automatic clearEntry(input int t, input string name);
        testName[t] = name;
        inValue[t] = '0;
        expCount[t] = 0;
        expIns[t] = 0;
        haltAddr[t] = '0;
        for (int k = 0; k < imageWords; k++) begin
            image[t][k] = instr(cpuPkg::HLT, 8'd0);
        end
        for (int k = 0; k < maxOuts; k++) begin
            expOut[t][k] = '0;
        end
    endtask

    task automatic expectOut(input int t, input logic [15:0] v);
        expOut[t][expCount[t]] = v;
        expCount[t]++;
    endtask

    // SUB then AND on the same pair and a jump over a repeat OUT after each.
    task automatic flagEntry(input int t, input string name, input logic [15:0] a,
            input logic [15:0] b, input cpuPkg::opcodeE j1, input cpuPkg::opcodeE j2);
        logic [15:0] r;
        logic c, z, l;
        clearEntry(t, name);
        haltAddr[t] = 8'd11;
        image[t][0] = instr(cpuPkg::LDX, dataA);
        image[t][1] = instr(cpuPkg::LDY, dataB);
        image[t][2] = instr(cpuPkg::SUB, 8'd0);
        image[t][3] = instr(cpuPkg::OUT, 8'd0);
        image[t][4] = instr(j1, 8'd6);
        image[t][5] = instr(cpuPkg::OUT, 8'd0);  // marker.
        image[t][6] = instr(cpuPkg::LDX, dataA);
        image[t][7] = instr(cpuPkg::AND, 8'd0);
        image[t][8] = instr(cpuPkg::OUT, 8'd0);
        image[t][9] = instr(j2, 8'd11);
        image[t][10] = instr(cpuPkg::OUT, 8'd0);  // marker.
        image[t][11] = instr(cpuPkg::HLT, 8'd0);
        image[t][dataA] = a;
        image[t][dataB] = b;
        r = aluModel(cpuPkg::SUB, a, b, c, z, l);
        expectOut(t, r);
        if (!jumpModel(j1, c, z, l)) begin
            expectOut(t, r);
        end
        r = aluModel(cpuPkg::AND, a, b, c, z, l);
        expectOut(t, r);
        if (!jumpModel(j2, c, z, l)) begin
            expectOut(t, r);
        end
    endtask

    task automatic countdownEntry(input int t, input string name, input logic [7:0] start);
        clearEntry(t, name);
        haltAddr[t] = 8'd6;
        image[t][0] = instr(cpuPkg::LDI, start);
        image[t][1] = instr(cpuPkg::LDY, dataA);
        image[t][2] = instr(cpuPkg::SUB, 8'd0);
        image[t][3] = instr(cpuPkg::OUT, 8'd0);  // loop head.
        image[t][4] = instr(cpuPkg::SUB, 8'd0);
        image[t][5] = instr(cpuPkg::JGT, 8'd3);
        image[t][6] = instr(cpuPkg::HLT, 8'd0);
        image[t][dataA] = 16'd1;
    endtask

    task automatic buildTable();
        logic [15:0] a;
        logic [15:0] b;
        logic [7:0]  v;
        a = randBits(16);
        b = randBits(16);
        clearEntry(0, "loadStore");
        haltAddr[0] = 8'd7;
        image[0][0] = instr(cpuPkg::LDX, dataA);
        image[0][1] = instr(cpuPkg::LDY, dataB);
        image[0][2] = instr(cpuPkg::ADD, 8'd0);
        image[0][3] = instr(cpuPkg::STX, dataC);
        image[0][4] = instr(cpuPkg::LDI, 8'd0);  // wipe X before reading back.
        image[0][5] = instr(cpuPkg::LDX, dataC);
        image[0][6] = instr(cpuPkg::OUT, 8'd0);
        image[0][dataA] = a;
        image[0][dataB] = b;
        expectOut(0, a + b);
        flagEntry(1, "flagsRandom", randBits(16), randBits(16), cpuPkg::JC, cpuPkg::JLT);
        a = randBits(16);
        flagEntry(2, "flagsEqual", a, a, cpuPkg::JZ, cpuPkg::JZ);
        v = 8'(randBits(8));
        clearEntry(3, "haltRestart");
        haltAddr[3] = 8'd2;
        image[3][0] = instr(cpuPkg::LDI, v);
        image[3][1] = instr(cpuPkg::OUT, 8'd0);
        image[3][2] = instr(cpuPkg::HLT, 8'd0);
        image[3][3] = instr(cpuPkg::OUT, 8'd0);  // never reached.
        expectOut(3, {8'h00, v});
        countdownEntry(4, "countdownHigh", 8'd5);
        expectOut(4, 16'd4);
        expectOut(4, 16'd3);
        expectOut(4, 16'd2);
        expectOut(4, 16'd1);
        countdownEntry(5, "countdownTail", 8'd1);
        expectOut(5, 16'd0);
        a = randBits(16);
        b = randBits(16);
        clearEntry(6, "extInput");
        inValue[6] = a;
        expIns[6] = 1;
        haltAddr[6] = 8'd5;
        image[6][0] = instr(cpuPkg::IN, 8'd0);
        image[6][1] = instr(cpuPkg::OUT, 8'd0);
        image[6][2] = instr(cpuPkg::LDY, dataA);
        image[6][3] = instr(cpuPkg::ADD, 8'd0);
        image[6][4] = instr(cpuPkg::OUT, 8'd0);
        image[6][dataA] = b;
        expectOut(6, a);
        expectOut(6, a + b);
    endtask

    task automatic checkValue(input string name, input string what,
            input logic [15:0] expected, input logic [15:0] actual);
        assert (actual === expected) else begin
            $display("** Error %s: %s expected %h actual %h", name, what, expected, actual);
            $display("Something failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "check failed");
    endtask

    task automatic runTest(input int t);
        int got;
        int ins;
        got = 0;
        ins = 0;
        // one loader write per reset cycle.
        for (int a = 0; a < imageWords; a++) begin
            @(posedge clk);
            rstN     <= 1'b0;
            progWe   <= 1'b1;
            progAddr <= 8'(a);
            progData <= image[t][a];
            inData   <= inValue[t];
        end
        @(posedge clk);
        rstN   <= 1'b1;
        progWe <= 1'b0;
        @(negedge clk);
        checkValue(testName[t], "halted after reset", 16'h0, 16'(halted));
        while (!halted) begin
            if (outStrobe) begin
                assert (got < expCount[t]) else
                    failRun({testName[t], ": the CPU produced more outputs than expected"});
                checkValue(testName[t], $sformatf("output %0d", got), expOut[t][got], outData);
                got++;
            end
            if (inStrobe) begin
                ins++;
            end
            @(negedge clk);
        end
        checkValue(testName[t], "output count", 16'(expCount[t]), 16'(got));
        checkValue(testName[t], "input strobe count", 16'(expIns[t]), 16'(ins));
        checkValue(testName[t], "address at halt", 16'(haltAddr[t]), 16'(addr));
        repeat (watchCycles) begin
            @(negedge clk);
            assert (!outStrobe) else
                failRun({testName[t], ": an output strobe appeared after the halt"});
            checkValue(testName[t], "halted", 16'h1, 16'(halted));
        end
    endtask

    initial begin
        rstN     = 1'b0;
        inData   = '0;
        progWe   = 1'b0;
        progAddr = '0;
        progData = '0;
        buildTable();
        for (int t = 0; t < numTests; t++) begin
            runTest(t);
        end
        $display("Everything OK");
        $finish;
    end

endmodule

//--- filelist.f
logic/cpuPkg.sv
logic/aluFlags.sv
logic/busDatapath.sv
logic/programCounter.sv
logic/programMemory.sv
logic/microSequencer.sv
logic/cpuTop.sv
sim/cpuTb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= cpuTb
FILELIST  ?= filelist.f
OBJDIR    ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# the simulator exits non-zero when the testbench stops with $fatal
run: compile
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
